// File: include/scc_defines.svh
`ifndef SCC_DEFINES_SVH
`define SCC_DEFINES_SVH

// CPU address window of the sound cartridge
`define SCC_AREA_LO   16'h9800   // First address inside the window
`define SCC_AREA_HI   16'hA000   // First address past the window

// Chip layout
`define SCC_NUM_SLOTS 2          // Chip instances in the cartridge block
`define SCC_NUM_CH    5          // Tone channels per chip
`define SCC_WAVE_LEN  32         // Samples per waveform block

// Register map inside the 256-byte chip page
// Wave RAM occupies 0x00 to 0x7F, channel 4 shares block 3
`define SCC_REG_FREQ  8'h80      // Low/high period byte pair per channel
`define SCC_REG_VOL   8'h8A      // One 4-bit volume per channel
`define SCC_REG_MASK  8'h8F      // Channel enable bits

`endif

// File: rtl/scc_pkg.sv
package scc_pkg;

    // Device kinds seen on the configuration bus
    typedef enum logic [2:0] {
        DEV_NONE   = 3'd0,  // Nothing addressed
        DEV_PSG    = 3'd1,  // Programmable sound generator
        DEV_SCC    = 3'd2,  // Wave-table sound cartridge
        DEV_OPLL   = 3'd3,  // FM sound unit
        DEV_MAPPER = 3'd4   // Memory mapper
    } dev_type_t;

    // One wave RAM entry, two's complement
    typedef logic signed [7:0] wave_sample_t;

    // Mixed output of a single chip
    // Five channels of 8-bit sample times 4-bit volume fit in 15 bits
    typedef logic signed [14:0] chip_sample_t;

    // Cartridge output after the slot mixer
    typedef logic signed [15:0] sound_t;

endpackage

// File: rtl/scc_slot.sv
`timescale 1ns/1ns

`include "scc_defines.svh"

module scc_slot (
    input  logic                       cpu_bus,     // CPU clock
    input  logic                       clk_en,      // Sound step enable
    input  logic                       reset,       // Sync reset, active high
    input  logic [15:0]                addr,        // CPU address
    input  logic [7:0]                 din,         // CPU write data
    input  logic                       wr,          // Write strobe
    input  logic                       rd,          // Read strobe
    input  scc_pkg::dev_type_t         dev_typ,     // Addressed device kind
    input  logic [3:0]                 dev_num,     // Device instance number
    input  logic                       dev_en,      // Enable value for the instance
    input  logic [`SCC_NUM_SLOTS-1:0]  mix_enable,  // Per-chip mixer enable
    output scc_pkg::sound_t            sound,       // Mixed cartridge audio
    output logic [7:0]                 data,        // Read data, 0xFF when idle
    output logic                       output_rq    // Read data valid
);

    logic [`SCC_NUM_SLOTS-1:0] slot_en;    // Enabled chip slots
    logic                      slot_sel;   // Slot picked by dev_num
    logic                      scc_area;   // Address inside the chip window
    logic                      cs;         // Chip select

    logic [7:0]                chip_dout [`SCC_NUM_SLOTS];  // Per-chip read data
    scc_pkg::chip_sample_t     chip_wave [`SCC_NUM_SLOTS];  // Per-chip samples

    assign slot_sel = dev_num[0];

    // Slot enables loaded from the configuration bus
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            slot_en <= '0;
        end else if (dev_typ == scc_pkg::DEV_SCC && dev_num < `SCC_NUM_SLOTS) begin
            slot_en[slot_sel] <= dev_en;
        end
    end

    // Window decode, upper bound exclusive
    assign scc_area = (addr >= `SCC_AREA_LO) && (addr < `SCC_AREA_HI);
    assign cs       = (dev_typ == scc_pkg::DEV_SCC) && scc_area && slot_en[slot_sel];

    // Same-cycle read, idle bus floats high
    assign output_rq = cs && rd;
    assign data      = output_rq ? chip_dout[slot_sel] : 8'hFF;

    for (genvar i = 0; i < `SCC_NUM_SLOTS; i++) begin : g_chip
        scc_wave u_wave (
            .cpu_bus (cpu_bus),
            .reset   (reset),
            .clk_en  (clk_en),
            .req     (cs && slot_sel == i),  // Only the addressed chip sees the access
            .wr      (wr),
            .adr     (addr[7:0]),            // Page offset inside the window
            .din     (din),
            .dout    (chip_dout[i]),
            .wave    (chip_wave[i])
        );
    end

    // Output mixer, sign-extended sum of enabled chips
    always_comb begin
        sound = '0;
        for (int i = 0; i < `SCC_NUM_SLOTS; i++) begin
            if (mix_enable[i]) begin
                sound = sound + scc_pkg::sound_t'(chip_wave[i]);
            end
        end
    end

endmodule

// File: rtl/scc_tone_channel.sv
`timescale 1ns/1ns

`include "scc_defines.svh"

module scc_tone_channel (
    input  logic                               cpu_bus,  // CPU clock
    input  logic                               reset,    // Sync reset, active high
    input  logic                               clk_en,   // Sound step enable
    input  logic [11:0]                        period,   // Reload value from the freq bytes
    input  logic                               restart,  // Freq register written
    output logic [$clog2(`SCC_WAVE_LEN)-1:0]   ptr       // Current sample index
);

    logic [11:0] count;  // Cycles left until the next sample step

    // Down-counter, reloads on reaching zero and steps the pointer
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            count <= '0;
            ptr   <= '0;
        end else if (restart) begin
            count <= '0;  // Restart the waveform from its first sample
            ptr   <= '0;
        end else if (clk_en) begin
            if (count == '0) begin
                count <= period;    // Next step after period+1 enabled cycles
                ptr   <= ptr + 1'b1; // Wraps at the end of the block
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/scc_wave.sv
`timescale 1ns/1ns

`include "scc_defines.svh"

module scc_wave (
    input  logic                  cpu_bus,  // CPU clock
    input  logic                  reset,    // Sync reset, active high
    input  logic                  clk_en,   // Sound step enable
    input  logic                  req,      // Chip selected this cycle
    input  logic                  wr,       // Write strobe
    input  logic [7:0]            adr,      // Offset inside the chip page
    input  logic [7:0]            din,      // Write data from the CPU
    output logic [7:0]            dout,     // Read data towards the CPU
    output scc_pkg::chip_sample_t wave      // Registered chip mix
);

    localparam int RAM_DEPTH = 4 * `SCC_WAVE_LEN;      // Four waveform blocks
    localparam int RAM_W     = $clog2(RAM_DEPTH);      // Wave RAM address width
    localparam int PTR_W     = $clog2(`SCC_WAVE_LEN);  // Sample index width

    scc_pkg::wave_sample_t wave_ram [RAM_DEPTH];  // Shared waveform storage

    logic                     wr_en;    // Accepted CPU write
    logic                     in_wave;  // Offset falls in the wave RAM
    logic [`SCC_NUM_CH-1:0]   mask;     // Channel enables
    logic signed [12:0]       ch_term [`SCC_NUM_CH];  // Sample times volume per channel
    scc_pkg::chip_sample_t    mix_sum;  // Combinational sum before the output register

    assign wr_en   = req && wr;
    assign in_wave = adr < `SCC_REG_FREQ;  // Registers start right after the RAM

    // Wave RAM write port
    always_ff @(posedge cpu_bus) begin
        if (wr_en && in_wave) begin
            wave_ram[adr[RAM_W-1:0]] <= din;
        end
    end

    // CPU read port, registers read back as open bus
    assign dout = in_wave ? wave_ram[adr[RAM_W-1:0]] : 8'hFF;

    // Channel enable register
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            mask <= '0;
        end else if (wr_en && adr == `SCC_REG_MASK) begin
            mask <= din[`SCC_NUM_CH-1:0];  // Upper bits ignored
        end
    end

    // Per-channel period, volume, tone generator and product
    for (genvar c = 0; c < `SCC_NUM_CH; c++) begin : g_ch
        localparam logic [7:0] FREQ_LO = 8'(`SCC_REG_FREQ + 2 * c);     // Period bits 7:0
        localparam logic [7:0] FREQ_HI = 8'(`SCC_REG_FREQ + 2 * c + 1); // Period bits 11:8
        localparam logic [7:0] VOL_ADR = 8'(`SCC_REG_VOL + c);
        localparam logic [1:0] BLK     = (c > 3) ? 2'd3 : 2'(c);  // Channel 4 reuses block 3

        logic [11:0]           period;   // Tone period
        logic [3:0]            vol;      // Channel volume
        logic                  restart;  // Period byte written
        logic [PTR_W-1:0]      ptr;      // Current sample index
        scc_pkg::wave_sample_t sample;   // Sample at the pointer

        assign restart = wr_en && (adr == FREQ_LO || adr == FREQ_HI);

        always_ff @(posedge cpu_bus) begin
            if (reset) begin
                period <= '0;
                vol    <= '0;
            end else if (wr_en) begin
                if (adr == FREQ_LO) begin
                    period[7:0] <= din;
                end
                if (adr == FREQ_HI) begin
                    period[11:8] <= din[3:0];  // Only a nibble is kept
                end
                if (adr == VOL_ADR) begin
                    vol <= din[3:0];
                end
            end
        end

        scc_tone_channel u_tone (
            .cpu_bus (cpu_bus),
            .reset   (reset),
            .clk_en  (clk_en),
            .period  (period),
            .restart (restart),
            .ptr     (ptr)
        );

        assign sample = wave_ram[{BLK, ptr}];

        // Volume is unsigned, widened so the product stays signed
        assign ch_term[c] = mask[c] ? sample * $signed({1'b0, vol}) : 13'sd0;
    end

    // Sum the channel products with sign extension
    always_comb begin
        mix_sum = '0;
        for (int c = 0; c < `SCC_NUM_CH; c++) begin
            mix_sum = mix_sum + scc_pkg::chip_sample_t'(ch_term[c]);
        end
    end

    // Output register, new sample one edge after a register write
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            wave <= '0;
        end else begin
            wave <= mix_sum;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the sound cartridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_scc_slot -o tb_scc_slot_sim

# Keep running past assertion errors so the testbench can print its verdict
./obj_dir/tb_scc_slot_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

# Pass only when the testbench printed its pass line
grep -q "^sim passed$" sim.log
echo "run_sim: simulation passed"

// File: testbench/scc_asserts.sv
`timescale 1ns/1ns

module scc_asserts (
    input logic       cpu_bus,    // CPU clock
    input logic       reset,      // Sync reset, active high
    input logic       rd,         // Read strobe
    input logic       output_rq,  // Read data valid
    input logic [7:0] data        // Read data
);

    int fail_count = 0;  // Failed assertions, read by the testbench at the end

    // A valid flag only answers a read strobe
    a_rq_needs_rd: assert property (@(posedge cpu_bus) output_rq |-> rd)
        else begin
            fail_count++;
            $error("output_rq high without a read strobe");
        end

    // Idle bus floats high
    a_idle_data: assert property (@(posedge cpu_bus) !output_rq |-> data == 8'hFF)
        else begin
            fail_count++;
            $error("data is not 0xFF while output_rq is low");
        end

    a_reset_quiet: assert property (@(posedge cpu_bus) reset |-> !output_rq)
        else begin
            fail_count++;
            $error("output_rq high during reset");
        end

endmodule

bind scc_slot scc_asserts u_asserts (
    .cpu_bus   (cpu_bus),
    .reset     (reset),
    .rd        (rd),
    .output_rq (output_rq),
    .data      (data)
);

// File: testbench/tb_scc_slot.sv
`timescale 1ns/1ns

`include "scc_defines.svh"

module tb_scc_slot;

    localparam int MAX_STEPS = 1024;               // Table capacity
    localparam int RAM_BYTES = 4 * `SCC_WAVE_LEN;  // Wave RAM size per chip

    typedef enum logic [1:0] {
        OP_CFG   = 2'd0,  // Load one slot enable
        OP_WRITE = 2'd1,  // CPU write into the window
        OP_READ  = 2'd2,  // CPU read, expect {rq, byte}
        OP_SOUND = 2'd3   // Set mix_enable, wait for the sample
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] addr;
        logic        slot;
        logic [7:0]  data;  // Write byte, enable bit or mix bits
        logic [15:0] exp;   // Expected read or sound value
    } step_t;

    logic                      cpu_bus;
    logic                      clk_en;
    logic                      reset;
    logic [15:0]               addr;
    logic [7:0]                din;
    logic                      wr;
    logic                      rd;
    scc_pkg::dev_type_t        dev_typ;
    logic [3:0]                dev_num;
    logic                      dev_en;
    logic [`SCC_NUM_SLOTS-1:0] mix_enable;
    scc_pkg::sound_t           sound;
    logic [7:0]                data;
    logic                      output_rq;

    step_t      steps [MAX_STEPS];               // Stimulus table
    int         num_steps;
    logic [7:0] ram_model [`SCC_NUM_SLOTS][RAM_BYTES];    // Expected wave RAM
    logic [3:0] vol_model [`SCC_NUM_SLOTS][`SCC_NUM_CH];  // Expected volumes
    logic [4:0] mask_model [`SCC_NUM_SLOTS];     // Expected channel masks
    logic       en_model [`SCC_NUM_SLOTS];       // Slot enables while building
    logic       slot_on [`SCC_NUM_SLOTS];        // Slot enables while driving
    int         errors;

    scc_slot dut (
        .cpu_bus    (cpu_bus),
        .clk_en     (clk_en),
        .reset      (reset),
        .addr       (addr),
        .din        (din),
        .wr         (wr),
        .rd         (rd),
        .dev_typ    (dev_typ),
        .dev_num    (dev_num),
        .dev_en     (dev_en),
        .mix_enable (mix_enable),
        .sound      (sound),
        .data       (data),
        .output_rq  (output_rq)
    );

    always #5 cpu_bus = ~cpu_bus;  // 10 ns period

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic add_step(input op_t op, input logic [15:0] a, input logic slot,
                            input logic [7:0] d, input logic [15:0] e);
        steps[num_steps].op   = op;
        steps[num_steps].addr = a;
        steps[num_steps].slot = slot;
        steps[num_steps].data = d;
        steps[num_steps].exp  = e;
        num_steps++;
    endtask

    task automatic add_cfg(input logic slot, input logic en);
        en_model[slot] = en;
        add_step(OP_CFG, 16'h0000, slot, {7'b0, en}, 16'h0000);
    endtask

    // Write at a page offset, model follows the register map
    task automatic add_write(input logic slot, input logic [7:0] off, input logic [7:0] d);
        add_step(OP_WRITE, `SCC_AREA_LO + {8'h00, off}, slot, d, 16'h0000);
        if (en_model[slot]) begin
            if (off < 8'h80) begin
                ram_model[slot][off[6:0]] = d;
            end
            for (int c = 0; c < `SCC_NUM_CH; c++) begin
                if (off == 8'(8'h8A + c)) begin
                    vol_model[slot][c] = d[3:0];
                end
            end
            if (off == 8'h8F) begin
                mask_model[slot] = d[4:0];
            end
        end
    endtask

    task automatic add_read(input logic slot, input logic [15:0] a);
        logic       hit;
        logic [7:0] byte_exp;
        hit      = en_model[slot] && a >= `SCC_AREA_LO && a < `SCC_AREA_HI;
        byte_exp = (hit && a[7:0] < 8'h80) ? ram_model[slot][a[6:0]] : 8'hFF;
        add_step(OP_READ, a, slot, 8'h00, {7'b0, hit, byte_exp});
    endtask

    // Pointers stay at 0, so each channel plays the first byte of its block
    function automatic logic [15:0] expected_sound(input logic [1:0] mix);
        int total;
        int blk;
        int sample;
        total = 0;
        for (int s = 0; s < `SCC_NUM_SLOTS; s++) begin
            for (int c = 0; c < `SCC_NUM_CH; c++) begin
                if (mix[s] && mask_model[s][c]) begin
                    blk    = (c < 4) ? c : 3;  // Channel 4 plays block 3
                    sample = $signed(ram_model[s][blk * `SCC_WAVE_LEN]);
                    total  = total + sample * int'(vol_model[s][c]);
                end
            end
        end
        return 16'(total);
    endfunction

    task automatic drive_bus(input scc_pkg::dev_type_t typ, input logic slot, input logic en,
                             input logic [15:0] a, input logic [7:0] d,
                             input logic w, input logic r);
        @(posedge cpu_bus);
        #1;
        dev_typ = typ;
        dev_num = {3'b000, slot};
        dev_en  = en;
        addr    = a;
        din     = d;
        wr      = w;
        rd      = r;
    endtask

    task automatic apply_step(input int idx);
        step_t st;
        string name;
        int    waited;
        logic  settled;
        st   = steps[idx];
        name = $sformatf("step %0d %s addr %h slot %0d", idx, st.op.name(), st.addr, st.slot);
        case (st.op)
            OP_CFG: begin
                drive_bus(scc_pkg::DEV_SCC, st.slot, st.data[0], 16'h0000, 8'h00, 1'b0, 1'b0);
                slot_on[st.slot] = st.data[0];
            end
            OP_WRITE: begin
                drive_bus(scc_pkg::DEV_SCC, st.slot, slot_on[st.slot], st.addr, st.data,
                          1'b1, 1'b0);
            end
            OP_READ: begin
                drive_bus(scc_pkg::DEV_SCC, st.slot, slot_on[st.slot], st.addr, 8'h00,
                          1'b0, 1'b1);
                @(negedge cpu_bus);  // Mid-cycle, combinational data is stable
                check_value(name, st.exp, {7'b0, output_rq, data});
            end
            default: begin
                drive_bus(scc_pkg::DEV_NONE, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b0, 1'b0);
                mix_enable = st.data[1:0];
                waited     = 0;
                settled    = 1'b0;
                while (!settled && waited < 5) begin  // Bounded settle wait
                    @(negedge cpu_bus);
                    settled = (sound === st.exp);
                    waited++;
                end
                if (!settled) begin
                    $display("sound did not reach its expected value within 5 cycles");
                end
                check_value(name, st.exp, sound);
            end
        endcase
    endtask

    initial begin
        int assert_fails;
        cpu_bus    = 1'b0;
        clk_en     = 1'b0;  // Tone pointers stay at 0
        reset      = 1'b1;
        addr       = 16'h0000;
        din        = 8'h00;
        wr         = 1'b0;
        rd         = 1'b0;
        dev_typ    = scc_pkg::DEV_NONE;
        dev_num    = 4'h0;
        dev_en     = 1'b0;
        mix_enable = 2'b00;
        errors     = 0;
        num_steps  = 0;
        void'($urandom(32'h8ccc_a1d0));  // One seed for the whole run
        for (int s = 0; s < `SCC_NUM_SLOTS; s++) begin
            en_model[s]   = 1'b0;
            slot_on[s]    = 1'b0;
            mask_model[s] = 5'h00;
            for (int c = 0; c < `SCC_NUM_CH; c++) vol_model[s][c] = 4'h0;
            for (int i = 0; i < RAM_BYTES; i++) ram_model[s][i] = 8'h00;
        end

        add_step(OP_SOUND, 16'h0000, 1'b0, 8'h03, expected_sound(2'b11));  // Silent after reset
        add_read(1'b0, 16'h9800);  // Slot 0 still disabled
        add_cfg(1'b0, 1'b1);
        for (int i = 0; i < RAM_BYTES; i++) add_write(1'b0, 8'(i), 8'($urandom));
        for (int i = 0; i < RAM_BYTES; i++) add_read(1'b0, 16'h9800 + 16'(i));
        add_read(1'b0, 16'h9FFF);  // Register area reads as 0xFF
        add_read(1'b0, 16'hA000);  // Just past the window
        add_read(1'b1, 16'h9800);  // Slot 1 still disabled
        add_cfg(1'b1, 1'b1);
        for (int i = 0; i < RAM_BYTES; i++) add_write(1'b1, 8'(i), 8'($urandom));
        for (int i = 0; i < RAM_BYTES; i++) add_read(1'b1, 16'h9800 + 16'(i));
        for (int i = 0; i < RAM_BYTES; i++) add_read(1'b0, 16'h9800 + 16'(i));
        add_write(1'b0, 8'h8A, 8'h05);  // Ch0 volume
        add_write(1'b0, 8'h8E, 8'h0F);  // Ch4 volume
        add_write(1'b0, 8'h8F, 8'h11);  // Ch0 and ch4 on
        add_write(1'b1, 8'h8C, 8'h07);  // Ch2 volume
        add_write(1'b1, 8'h8F, 8'h04);  // Ch2 on
        for (int m = 3; m >= 0; m--) begin
            add_step(OP_SOUND, 16'h0000, 1'b0, 8'(m), expected_sound(2'(m)));
        end
        add_write(1'b0, 8'h8F, 8'h00);  // Mute slot 0
        add_step(OP_SOUND, 16'h0000, 1'b0, 8'h03, expected_sound(2'b11));
        add_cfg(1'b1, 1'b0);
        add_read(1'b1, 16'h9800);  // Disabled slot floats high
        add_step(OP_SOUND, 16'h0000, 1'b0, 8'h03, expected_sound(2'b11));

        repeat (4) @(posedge cpu_bus);
        #1;
        reset = 1'b0;

        for (int i = 0; i < num_steps; i++) apply_step(i);
        drive_bus(scc_pkg::DEV_NONE, 1'b0, 1'b0, 16'h0000, 8'h00, 1'b0, 1'b0);
        repeat (2) @(posedge cpu_bus);

        assert_fails = dut.u_asserts.fail_count;
        $display("%0d steps, %0d check errors, %0d assertion failures",
                 num_steps, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/scc_pkg.sv
rtl/scc_tone_channel.sv
rtl/scc_wave.sv
rtl/scc_slot.sv
testbench/scc_asserts.sv
testbench/tb_scc_slot.sv
